// File: sources.f
+incdir+source
+incdir+dv
source/sched_pkg.sv
source/issue_if.sv
source/issue_queue.sv
source/instr_decoder.sv
source/int_regfile.sv
source/dispatch_former.sv
source/be_scheduler.sv
dv/tb_be_scheduler.sv

// File: Makefile
LOG = sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing -f sources.f --top-module tb_be_scheduler -o sim_tb
	./obj_dir/sim_tb | tee $(LOG)
	grep -q "ALL CHECKS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: dv/sched_model.svh
// Reference model state, decode function and queue helpers for the scheduler testbench
`ifndef SCHED_MODEL_SVH
`define SCHED_MODEL_SVH

logic [`SCHED_XLEN-1:0] m_regs  [32];
logic [`SCHED_XLEN-1:0] m_pc    [`SCHED_QUEUE_DEPTH];
logic [`SCHED_XLEN-1:0] m_instr [`SCHED_QUEUE_DEPTH];
fe_fault_e              m_fault [`SCHED_QUEUE_DEPTH];
logic [`SCHED_PTR_W:0]  m_wr;
logic [`SCHED_PTR_W:0]  m_rd;
logic [`SCHED_PTR_W:0]  m_cm;

function automatic void model_reset();
  for (int i = 0; i < 32; i++) begin
    m_regs[i] = '0;
  end
  for (int i = 0; i < `SCHED_QUEUE_DEPTH; i++) begin
    m_pc[i]    = '0;
    m_instr[i] = '0;
    m_fault[i] = FE_NONE;
  end
  m_wr = '0;
  m_rd = '0;
  m_cm = '0;
endfunction

// Entries held since the last commit
function automatic logic model_full();
  logic [`SCHED_PTR_W:0] used_cnt;
  used_cnt = m_wr - m_cm;
  return used_cnt == {1'b1, {`SCHED_PTR_W{1'b0}}};
endfunction

// Subset of the RV32I encoding table
function automatic decode_s model_decode(logic [31:0] w);
  decode_s d;
  d          = '0;
  d.rs1_addr = w[19:15];
  d.rs2_addr = w[24:20];
  d.exc      = EXC_NONE;
  casez (w)
    32'b0000000_?????_?????_000_?????_0110011: d.op = OP_ADD;
    32'b0100000_?????_?????_000_?????_0110011: d.op = OP_SUB;
    32'b0000000_?????_?????_111_?????_0110011: d.op = OP_AND;
    32'b0000000_?????_?????_110_?????_0110011: d.op = OP_OR;
    32'b0000000_?????_?????_100_?????_0110011: d.op = OP_XOR;
    32'b???????_?????_?????_000_?????_0010011: d.op = OP_ADDI;
    32'b???????_?????_?????_010_?????_0000011: d.op = OP_LW;
    32'b???????_?????_?????_010_?????_0100011: d.op = OP_SW;
    32'b???????_?????_?????_000_?????_1100011: d.op = OP_BEQ;
    32'b???????_?????_?????_???_?????_1101111: d.op = OP_JAL;
    32'h0000_0073: d.exc = EXC_ECALL;
    32'h0010_0073: d.exc = EXC_EBREAK;
    32'h3020_0073: d.op  = OP_MRET;
    32'h1050_0073: d.op  = OP_WFI;
    default:       d.exc = EXC_ILLEGAL;
  endcase
  case (d.op)
    OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR: begin
      d.rs1_used = 1'b1;
      d.rs2_used = 1'b1;
    end
    OP_ADDI, OP_LW: begin
      d.rs1_used = 1'b1;
      d.imm      = {{20{w[31]}}, w[31:20]};
    end
    OP_SW: begin
      d.rs1_used = 1'b1;
      d.rs2_used = 1'b1;
      d.imm      = {{20{w[31]}}, w[31:25], w[11:7]};
    end
    OP_BEQ: begin
      d.rs1_used = 1'b1;
      d.rs2_used = 1'b1;
      d.imm      = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
    end
    OP_JAL: d.imm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
    default: ;
  endcase
  return d;
endfunction

`endif

// File: dv/tb_be_scheduler.sv
// Testbench for be_scheduler: LFSR stimulus, model compare, watchdog and report
`timescale 1ns/1ns
`include "sched_defs.svh"

module tb_be_scheduler;

  import sched_pkg::*;

  `include "sched_model.svh"

  localparam logic [31:0] LFSR_SEED = 32'd62;
  localparam int RESET_CYCLES  = 5;
  localparam int DECODE_CYCLES = 61;
  localparam int EVENT_CYCLES  = 22;
  localparam int FAULT_CYCLES  = 25;
  localparam int ROLL_CYCLES   = 23;
  localparam int FULL_CYCLES   = 21;
  localparam int CLEAR_CYCLES  = 11;
  localparam int TOTAL_CYCLES  = RESET_CYCLES + 1 + DECODE_CYCLES + EVENT_CYCLES +
                                 FAULT_CYCLES + ROLL_CYCLES + FULL_CYCLES + CLEAR_CYCLES;
  localparam int TIMEOUT_NS    = 20 * TOTAL_CYCLES * 2 + 2000;

  logic clk_i;
  logic arst_n_i;
  logic fe_v_i;
  logic [`SCHED_XLEN-1:0] fe_pc_i;
  logic [`SCHED_XLEN-1:0] fe_instr_i;
  fe_fault_e fe_fault_i;
  logic fe_ready_o;
  logic commit_deq_i;
  logic commit_roll_i;
  logic clear_i;
  logic suppress_i;
  logic dispatch_v_i;
  logic poison_i;
  logic [`SCHED_XLEN-1:0] expected_npc_i;
  logic fill_v_i;
  logic [`SCHED_XLEN-1:0] fill_vaddr_i;
  logic [`SCHED_XLEN-1:0] fill_data_i;
  logic unfreeze_i;
  logic interrupt_v_i;
  logic wb_v_i;
  logic [`SCHED_REG_ADDR_W-1:0] wb_addr_i;
  logic [`SCHED_XLEN-1:0] wb_data_i;
  logic dispatch_v_o;
  logic dispatch_queue_v_o;
  logic dispatch_instr_v_o;
  logic [`SCHED_XLEN-1:0] dispatch_pc_o;
  sched_op_e dispatch_op_o;
  sched_exc_e dispatch_exc_o;
  logic [`SCHED_XLEN-1:0] dispatch_rs1_o;
  logic [`SCHED_XLEN-1:0] dispatch_rs2_o;
  logic [`SCHED_XLEN-1:0] dispatch_imm_o;

  // Expected outputs for the current cycle
  logic exp_v;
  logic exp_read;
  logic exp_instr_v;
  logic exp_ready;
  sched_op_e exp_op;
  sched_exc_e exp_exc;
  logic [`SCHED_XLEN-1:0] exp_rs1;
  logic [`SCHED_XLEN-1:0] exp_rs2;
  logic [`SCHED_XLEN-1:0] exp_imm;

  logic [31:0] lfsr_state;
  string test_name;
  int checks;
  int errors;
  int start_checks;
  int start_errors;

  be_scheduler u_be_scheduler (.*);

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      if (lfsr_state[0]) begin
        lfsr_state = (lfsr_state >> 1) ^ 32'h8020_0003;
      end else begin
        lfsr_state = lfsr_state >> 1;
      end
      r = {r[30:0], lfsr_state[0]};
    end
    return r;
  endfunction

  // Mostly subset encodings with random register and immediate fields
  function automatic logic [31:0] rand_instr();
    logic [31:0] w;
    logic [3:0] kind;
    w = rand_bits(32);
    kind = 4'(rand_bits(4));
    case (kind)
      4'd0: w = {7'b0000000, w[24:15], 3'b000, w[11:7], 7'b0110011};
      4'd1: w = {7'b0100000, w[24:15], 3'b000, w[11:7], 7'b0110011};
      4'd2: w = {7'b0000000, w[24:15], 3'b111, w[11:7], 7'b0110011};
      4'd3: w = {7'b0000000, w[24:15], 3'b110, w[11:7], 7'b0110011};
      4'd4: w = {7'b0000000, w[24:15], 3'b100, w[11:7], 7'b0110011};
      4'd5: w = {w[31:15], 3'b000, w[11:7], 7'b0010011};
      4'd6: w = {w[31:15], 3'b010, w[11:7], 7'b0000011};
      4'd7: w = {w[31:15], 3'b010, w[11:7], 7'b0100011};
      4'd8: w = {w[31:15], 3'b000, w[11:7], 7'b1100011};
      4'd9: w = {w[31:7], 7'b1101111};
      4'd10: w = 32'h0000_0073;
      4'd11: w = 32'h0010_0073;
      4'd12: w = 32'h3020_0073;
      4'd13: w = 32'h1050_0073;
      4'd14: w = {w[31:7], 7'b1111111};
      default: ;
    endcase
    return w;
  endfunction

  function automatic fe_fault_e rand_fault();
    logic [1:0] r;
    r = 2'(rand_bits(2));
    case (r)
      2'd0: return FE_NONE;
      2'd1: return FE_ACCESS;
      default: return FE_PAGE;
    endcase
  endfunction

  task automatic check_flag(string what, logic exp, logic act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("mismatch %s %s: expected %b, actual %b", test_name, what, exp, act);
    end
  endtask

  task automatic check_word(string what, logic [`SCHED_XLEN-1:0] exp,
                            logic [`SCHED_XLEN-1:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("mismatch %s %s: expected %h, actual %h", test_name, what, exp, act);
    end
  endtask

  task automatic check_op(string what, sched_op_e exp, sched_op_e act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("mismatch %s %s: expected %s, actual %s (%0d)", test_name, what,
               exp.name(), act.name(), act);
    end
  endtask

  task automatic check_exc(string what, sched_exc_e exp, sched_exc_e act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("mismatch %s %s: expected %s, actual %s (%0d)", test_name, what,
               exp.name(), act.name(), act);
    end
  endtask

  task automatic compute_expected();
    decode_s d;
    logic inject;
    logic [`SCHED_PTR_W-1:0] h;
    h = m_rd[`SCHED_PTR_W-1:0];
    d = model_decode(m_instr[h]);
    inject = fill_v_i | unfreeze_i | interrupt_v_i;
    exp_read = !inject && dispatch_v_i && !poison_i && (m_rd != m_wr);
    exp_v = exp_read | inject;
    exp_instr_v = exp_read && (m_fault[h] == FE_NONE);
    exp_ready = !model_full() && !suppress_i;
    exp_op = OP_NONE;
    exp_exc = EXC_NONE;
    exp_rs1 = '0;
    exp_rs2 = '0;
    exp_imm = '0;
    if (fill_v_i) begin
      exp_exc = EXC_FILL;
      exp_rs1 = fill_vaddr_i;
      exp_rs2 = fill_data_i;
    end else if (unfreeze_i) begin
      exp_exc = EXC_UNFREEZE;
    end else if (interrupt_v_i) begin
      exp_exc = EXC_INTERRUPT;
    end else if (exp_read && !exp_instr_v) begin
      exp_exc = (m_fault[h] == FE_ACCESS) ? EXC_FETCH_ACCESS : EXC_FETCH_PAGE;
      exp_rs1 = m_pc[h];
    end else if (exp_instr_v) begin
      exp_op = d.op;
      exp_exc = d.exc;
      exp_rs1 = d.rs1_used ? m_regs[d.rs1_addr] : '0;
      exp_rs2 = d.rs2_used ? m_regs[d.rs2_addr] : '0;
      exp_imm = d.imm;
    end
  endtask

  task automatic check_outputs();
    check_flag("dispatch_v_o", exp_v, dispatch_v_o);
    check_flag("dispatch_queue_v_o", exp_read, dispatch_queue_v_o);
    check_flag("dispatch_instr_v_o", exp_instr_v, dispatch_instr_v_o);
    check_flag("fe_ready_o", exp_ready, fe_ready_o);
    check_word("dispatch_pc_o", expected_npc_i, dispatch_pc_o);
    check_op("dispatch_op_o", exp_op, dispatch_op_o);
    check_exc("dispatch_exc_o", exp_exc, dispatch_exc_o);
    check_word("dispatch_rs1_o", exp_rs1, dispatch_rs1_o);
    check_word("dispatch_rs2_o", exp_rs2, dispatch_rs2_o);
    check_word("dispatch_imm_o", exp_imm, dispatch_imm_o);
  endtask

  // Model state as the DUT holds it after the coming rising edge
  task automatic model_step();
    logic wr_en;
    wr_en = fe_v_i && exp_ready;
    if (wr_en) begin
      m_pc[m_wr[`SCHED_PTR_W-1:0]]    = fe_pc_i;
      m_instr[m_wr[`SCHED_PTR_W-1:0]] = fe_instr_i;
      m_fault[m_wr[`SCHED_PTR_W-1:0]] = fe_fault_i;
    end
    if (clear_i) begin
      m_rd = m_wr;
      m_cm = m_wr;
    end else if (commit_roll_i) begin
      m_rd = m_cm;
    end else begin
      if (exp_read) begin
        m_rd = m_rd + 1'b1;
      end
      if (commit_deq_i) begin
        m_cm = m_cm + 1'b1;
      end
    end
    if (wr_en) begin
      m_wr = m_wr + 1'b1;
    end
    if (wb_v_i && wb_addr_i != '0) begin
      m_regs[wb_addr_i] = wb_data_i;
    end
  endtask

  task automatic drive_idle();
    fe_v_i = 1'b0;
    fe_pc_i = '0;
    fe_instr_i = '0;
    fe_fault_i = FE_NONE;
    commit_deq_i = 1'b0;
    commit_roll_i = 1'b0;
    clear_i = 1'b0;
    suppress_i = 1'b0;
    dispatch_v_i = 1'b0;
    poison_i = 1'b0;
    expected_npc_i = rand_bits(32);
    fill_v_i = 1'b0;
    fill_vaddr_i = '0;
    fill_data_i = '0;
    unfreeze_i = 1'b0;
    interrupt_v_i = 1'b0;
    wb_v_i = 1'(rand_bits(1));
    wb_addr_i = 5'(rand_bits(5));
    wb_data_i = rand_bits(32);
  endtask

  task automatic begin_cycle();
    @(negedge clk_i);
    drive_idle();
  endtask

  // Sample shortly before the rising edge, then advance the model
  task automatic end_cycle();
    #8;
    compute_expected();
    check_outputs();
    model_step();
  endtask

  task automatic fetch_entry(fe_fault_e fault);
    fe_v_i = 1'b1;
    fe_pc_i = rand_bits(32);
    fe_instr_i = rand_instr();
    fe_fault_i = fault;
  endtask

  task automatic clear_queue();
    begin_cycle();
    clear_i = 1'b1;
    end_cycle();
  endtask

  task automatic start_test(string name);
    test_name = name;
    start_checks = checks;
    start_errors = errors;
  endtask

  task automatic finish_test();
    $display("test %s: %0d checks, %0d errors", test_name, checks - start_checks,
             errors - start_errors);
  endtask

  task automatic run_decode_test();
    start_test("decode");
    for (int i = 0; i < 10; i++) begin
      begin_cycle();
      wb_v_i = 1'b1;
      end_cycle();
    end
    begin_cycle();
    fetch_entry(FE_NONE);
    fe_instr_i = 32'hffff_ffff;
    // Writeback to x0 that must not be seen by the read below
    wb_v_i = 1'b1;
    wb_addr_i = '0;
    wb_data_i = 32'hffff_ffff;
    end_cycle();
    // add x5, x0, x0
    begin_cycle();
    fetch_entry(FE_NONE);
    fe_instr_i = 32'h0000_02b3;
    dispatch_v_i = 1'b1;
    end_cycle();
    for (int i = 0; i < 48; i++) begin
      begin_cycle();
      fetch_entry(FE_NONE);
      dispatch_v_i = 1'b1;
      commit_deq_i = (m_cm != m_rd);
      end_cycle();
    end
    clear_queue();
    finish_test();
  endtask

  task automatic run_event_test();
    start_test("events");
    begin_cycle();
    fetch_entry(FE_NONE);
    end_cycle();
    for (int i = 0; i < 20; i++) begin
      begin_cycle();
      dispatch_v_i = 1'b1;
      fill_v_i = 1'(rand_bits(1));
      unfreeze_i = 1'(rand_bits(1));
      interrupt_v_i = 1'(rand_bits(1));
      if (!fill_v_i && !unfreeze_i) begin
        interrupt_v_i = 1'b1;
      end
      fill_vaddr_i = rand_bits(32);
      fill_data_i = rand_bits(32);
      end_cycle();
    end
    clear_queue();
    finish_test();
  endtask

  task automatic run_fault_test();
    start_test("fetch_fault");
    for (int i = 0; i < 24; i++) begin
      begin_cycle();
      fetch_entry(rand_fault());
      dispatch_v_i = 1'b1;
      commit_deq_i = (m_cm != m_rd);
      end_cycle();
    end
    clear_queue();
    finish_test();
  endtask

  task automatic run_roll_test();
    start_test("roll");
    for (int i = 0; i < 5; i++) begin
      begin_cycle();
      fetch_entry(rand_fault());
      end_cycle();
    end
    for (int pass = 0; pass < 2; pass++) begin
      for (int i = 0; i < 8; i++) begin
        begin_cycle();
        dispatch_v_i = 1'b1;
        poison_i = 1'(rand_bits(1));
        end_cycle();
      end
      if (pass == 0) begin
        begin_cycle();
        commit_roll_i = 1'b1;
        end_cycle();
      end
    end
    clear_queue();
    finish_test();
  endtask

  task automatic run_full_test();
    start_test("backpressure");
    for (int i = 0; i < 10; i++) begin
      begin_cycle();
      fetch_entry(FE_NONE);
      end_cycle();
    end
    begin_cycle();
    dispatch_v_i = 1'b1;
    end_cycle();
    begin_cycle();
    commit_deq_i = 1'b1;
    end_cycle();
    begin_cycle();
    fetch_entry(FE_NONE);
    end_cycle();
    clear_queue();
    for (int i = 0; i < 6; i++) begin
      begin_cycle();
      fetch_entry(FE_NONE);
      suppress_i = 1'(rand_bits(1));
      end_cycle();
    end
    clear_queue();
    finish_test();
  endtask

  task automatic run_clear_test();
    start_test("clear");
    for (int i = 0; i < 3; i++) begin
      begin_cycle();
      fetch_entry(FE_NONE);
      end_cycle();
    end
    begin_cycle();
    dispatch_v_i = 1'b1;
    end_cycle();
    clear_queue();
    for (int i = 0; i < 3; i++) begin
      begin_cycle();
      dispatch_v_i = 1'b1;
      end_cycle();
    end
    begin_cycle();
    fetch_entry(FE_NONE);
    dispatch_v_i = 1'b1;
    end_cycle();
    begin_cycle();
    dispatch_v_i = 1'b1;
    end_cycle();
    clear_queue();
    finish_test();
  endtask

  initial begin
    #(TIMEOUT_NS);
    $display("timeout: run did not finish within %0d ns", TIMEOUT_NS);
    $display("CHECKS FAILED");
    $finish;
  end

  initial begin
    checks = 0;
    errors = 0;
    test_name = "reset";
    lfsr_state = LFSR_SEED;
    arst_n_i = 1'b0;
    drive_idle();
    // No writeback on the first edge out of reset
    wb_v_i = 1'b0;
    model_reset();
    repeat (RESET_CYCLES) @(posedge clk_i);
    @(negedge clk_i);
    arst_n_i = 1'b1;
    run_decode_test();
    run_event_test();
    run_fault_test();
    run_roll_test();
    run_full_test();
    run_clear_test();
    $display("total: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// File: source/be_scheduler.sv
// Back-end scheduler top: issue queue, decoder, register file, dispatch former
`timescale 1ns/1ns
`include "sched_defs.svh"

module be_scheduler (
  input  logic                         clk_i,
  input  logic                         arst_n_i,

  input  logic                         fe_v_i,
  input  logic [`SCHED_XLEN-1:0]       fe_pc_i,
  input  logic [`SCHED_XLEN-1:0]       fe_instr_i,
  input  sched_pkg::fe_fault_e         fe_fault_i,
  output logic                         fe_ready_o,

  input  logic                         commit_deq_i,
  input  logic                         commit_roll_i,
  input  logic                         clear_i,
  input  logic                         suppress_i,

  input  logic                         dispatch_v_i,
  input  logic                         poison_i,
  input  logic [`SCHED_XLEN-1:0]       expected_npc_i,

  input  logic                         fill_v_i,
  input  logic [`SCHED_XLEN-1:0]       fill_vaddr_i,
  input  logic [`SCHED_XLEN-1:0]       fill_data_i,
  input  logic                         unfreeze_i,
  input  logic                         interrupt_v_i,

  input  logic                         wb_v_i,
  input  logic [`SCHED_REG_ADDR_W-1:0] wb_addr_i,
  input  logic [`SCHED_XLEN-1:0]       wb_data_i,

  output logic                         dispatch_v_o,
  output logic                         dispatch_queue_v_o,
  output logic                         dispatch_instr_v_o,
  output logic [`SCHED_XLEN-1:0]       dispatch_pc_o,
  output sched_pkg::sched_op_e         dispatch_op_o,
  output sched_pkg::sched_exc_e        dispatch_exc_o,
  output logic [`SCHED_XLEN-1:0]       dispatch_rs1_o,
  output logic [`SCHED_XLEN-1:0]       dispatch_rs2_o,
  output logic [`SCHED_XLEN-1:0]       dispatch_imm_o
);

  import sched_pkg::*;

  decode_s                decode;
  logic [`SCHED_XLEN-1:0] rs1_data;
  logic [`SCHED_XLEN-1:0] rs2_data;

  issue_if issue ();

  issue_queue u_issue_queue (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .fe_v_i     (fe_v_i),
    .fe_pc_i    (fe_pc_i),
    .fe_instr_i (fe_instr_i),
    .fe_fault_i (fe_fault_i),
    .fe_ready_o (fe_ready_o),
    .deq_i      (commit_deq_i),
    .roll_i     (commit_roll_i),
    .clear_i    (clear_i),
    .suppress_i (suppress_i),
    .issue      (issue.queue)
  );

  instr_decoder u_instr_decoder (
    .issue    (issue.decode),
    .decode_o (decode)
  );

  int_regfile u_int_regfile (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .wr_v_i     (wb_v_i),
    .wr_addr_i  (wb_addr_i),
    .wr_data_i  (wb_data_i),
    .rs1_addr_i (decode.rs1_addr),
    .rs2_addr_i (decode.rs2_addr),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data)
  );

  dispatch_former u_dispatch_former (
    .issue              (issue.dispatch),
    .decode_i           (decode),
    .rs1_data_i         (rs1_data),
    .rs2_data_i         (rs2_data),
    .dispatch_v_i       (dispatch_v_i),
    .poison_i           (poison_i),
    .expected_npc_i     (expected_npc_i),
    .fill_v_i           (fill_v_i),
    .fill_vaddr_i       (fill_vaddr_i),
    .fill_data_i        (fill_data_i),
    .unfreeze_i         (unfreeze_i),
    .interrupt_v_i      (interrupt_v_i),
    .dispatch_v_o       (dispatch_v_o),
    .dispatch_queue_v_o (dispatch_queue_v_o),
    .dispatch_instr_v_o (dispatch_instr_v_o),
    .dispatch_pc_o      (dispatch_pc_o),
    .dispatch_op_o      (dispatch_op_o),
    .dispatch_exc_o     (dispatch_exc_o),
    .dispatch_rs1_o     (dispatch_rs1_o),
    .dispatch_rs2_o     (dispatch_rs2_o),
    .dispatch_imm_o     (dispatch_imm_o)
  );

endmodule

// File: source/dispatch_former.sv
// Event priority, queue read decision and dispatch packet assembly
`timescale 1ns/1ns
`include "sched_defs.svh"

module dispatch_former (
  issue_if.dispatch              issue,
  input  sched_pkg::decode_s     decode_i,
  input  logic [`SCHED_XLEN-1:0] rs1_data_i,
  input  logic [`SCHED_XLEN-1:0] rs2_data_i,

  input  logic                   dispatch_v_i,
  input  logic                   poison_i,
  input  logic [`SCHED_XLEN-1:0] expected_npc_i,

  input  logic                   fill_v_i,
  input  logic [`SCHED_XLEN-1:0] fill_vaddr_i,
  input  logic [`SCHED_XLEN-1:0] fill_data_i,
  input  logic                   unfreeze_i,
  input  logic                   interrupt_v_i,

  output logic                   dispatch_v_o,
  output logic                   dispatch_queue_v_o,
  output logic                   dispatch_instr_v_o,
  output logic [`SCHED_XLEN-1:0] dispatch_pc_o,
  output sched_pkg::sched_op_e   dispatch_op_o,
  output sched_pkg::sched_exc_e  dispatch_exc_o,
  output logic [`SCHED_XLEN-1:0] dispatch_rs1_o,
  output logic [`SCHED_XLEN-1:0] dispatch_rs2_o,
  output logic [`SCHED_XLEN-1:0] dispatch_imm_o
);

  import sched_pkg::*;

  logic inject;
  logic read;
  logic instr_v;
  logic fe_exc_v;

  // Back-end events win over the queue head
  assign inject   = fill_v_i | unfreeze_i | interrupt_v_i;
  assign read     = ~inject & dispatch_v_i & ~poison_i & issue.v;
  assign instr_v  = read & (issue.fault == FE_NONE);
  assign fe_exc_v = read & (issue.fault != FE_NONE);

  assign issue.read_v = read;

  assign dispatch_v_o       = read | inject;
  assign dispatch_queue_v_o = read;
  assign dispatch_instr_v_o = instr_v;
  assign dispatch_pc_o      = expected_npc_i;

  always_comb begin
    dispatch_op_o  = OP_NONE;
    dispatch_exc_o = EXC_NONE;
    dispatch_rs1_o = '0;
    dispatch_rs2_o = '0;
    dispatch_imm_o = '0;
    if (fill_v_i) begin
      dispatch_exc_o = EXC_FILL;
      dispatch_rs1_o = fill_vaddr_i;
      dispatch_rs2_o = fill_data_i;
    end else if (unfreeze_i) begin
      dispatch_exc_o = EXC_UNFREEZE;
    end else if (interrupt_v_i) begin
      dispatch_exc_o = EXC_INTERRUPT;
    end else if (fe_exc_v) begin
      dispatch_exc_o = (issue.fault == FE_PAGE) ? EXC_FETCH_PAGE : EXC_FETCH_ACCESS;
      // Faulting pc goes out as the trap value
      dispatch_rs1_o = issue.pc;
    end else if (instr_v) begin
      dispatch_op_o  = decode_i.op;
      dispatch_exc_o = decode_i.exc;
      dispatch_rs1_o = decode_i.rs1_used ? rs1_data_i : '0;
      dispatch_rs2_o = decode_i.rs2_used ? rs2_data_i : '0;
      dispatch_imm_o = decode_i.imm;
    end
  end

endmodule

// File: source/int_regfile.sv
// Integer register file, two combinational reads and one clocked write
`timescale 1ns/1ns
`include "sched_defs.svh"

module int_regfile (
  input  logic                         clk_i,
  input  logic                         arst_n_i,

  input  logic                         wr_v_i,
  input  logic [`SCHED_REG_ADDR_W-1:0] wr_addr_i,
  input  logic [`SCHED_XLEN-1:0]       wr_data_i,

  input  logic [`SCHED_REG_ADDR_W-1:0] rs1_addr_i,
  input  logic [`SCHED_REG_ADDR_W-1:0] rs2_addr_i,
  output logic [`SCHED_XLEN-1:0]       rs1_data_o,
  output logic [`SCHED_XLEN-1:0]       rs2_data_o
);

  // No storage for x0
  logic [`SCHED_XLEN-1:0] regs [1:31];

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_v_i && wr_addr_i != '0) begin
      regs[wr_addr_i] <= wr_data_i;
    end
  end

  assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
  assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];

endmodule

// File: source/instr_decoder.sv
// Integer subset decoder from instruction word to decode struct
`timescale 1ns/1ns
`include "sched_defs.svh"

module instr_decoder (
  issue_if.decode            issue,
  output sched_pkg::decode_s decode_o
);

  import sched_pkg::*;

  typedef enum logic [6:0] {
    RV_LOAD   = 7'b0000011,
    RV_OP_IMM = 7'b0010011,
    RV_STORE  = 7'b0100011,
    RV_OP     = 7'b0110011,
    RV_BRANCH = 7'b1100011,
    RV_JAL    = 7'b1101111,
    RV_SYSTEM = 7'b1110011
  } rv_opcode_e;

  logic [`SCHED_XLEN-1:0] instr;
  logic [6:0]             opcode;
  logic [2:0]             funct3;
  logic [6:0]             funct7;
  logic [`SCHED_XLEN-1:0] imm_i;
  logic [`SCHED_XLEN-1:0] imm_s;
  logic [`SCHED_XLEN-1:0] imm_b;
  logic [`SCHED_XLEN-1:0] imm_j;

  assign instr  = issue.instr;
  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  // Sign-extended immediates per format
  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  always_comb begin
    decode_o          = '0;
    decode_o.rs1_addr = instr[19:15];
    decode_o.rs2_addr = instr[24:20];
    decode_o.exc      = EXC_ILLEGAL;
    case (opcode)
      RV_OP: begin
        if (funct7 == 7'b0000000) begin
          case (funct3)
            3'b000:  decode_o.op = OP_ADD;
            3'b111:  decode_o.op = OP_AND;
            3'b110:  decode_o.op = OP_OR;
            3'b100:  decode_o.op = OP_XOR;
            default: decode_o.op = OP_NONE;
          endcase
        end else if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
          decode_o.op = OP_SUB;
        end
        decode_o.rs1_used = 1'b1;
        decode_o.rs2_used = 1'b1;
      end
      RV_OP_IMM: begin
        decode_o.op       = (funct3 == 3'b000) ? OP_ADDI : OP_NONE;
        decode_o.imm      = imm_i;
        decode_o.rs1_used = 1'b1;
      end
      RV_LOAD: begin
        decode_o.op       = (funct3 == 3'b010) ? OP_LW : OP_NONE;
        decode_o.imm      = imm_i;
        decode_o.rs1_used = 1'b1;
      end
      RV_STORE: begin
        decode_o.op       = (funct3 == 3'b010) ? OP_SW : OP_NONE;
        decode_o.imm      = imm_s;
        decode_o.rs1_used = 1'b1;
        decode_o.rs2_used = 1'b1;
      end
      RV_BRANCH: begin
        decode_o.op       = (funct3 == 3'b000) ? OP_BEQ : OP_NONE;
        decode_o.imm      = imm_b;
        decode_o.rs1_used = 1'b1;
        decode_o.rs2_used = 1'b1;
      end
      RV_JAL: begin
        decode_o.op  = OP_JAL;
        decode_o.imm = imm_j;
      end
      RV_SYSTEM: begin
        // Whole-word match since CSR forms are outside the subset
        case (instr)
          32'h0000_0073: decode_o.exc = EXC_ECALL;
          32'h0010_0073: decode_o.exc = EXC_EBREAK;
          32'h3020_0073: decode_o.op  = OP_MRET;
          32'h1050_0073: decode_o.op  = OP_WFI;
          default:       decode_o.op  = OP_NONE;
        endcase
      end
      default: decode_o.op = OP_NONE;
    endcase
    if (decode_o.op != OP_NONE) begin
      decode_o.exc = EXC_NONE;
    end
    if (decode_o.exc == EXC_ILLEGAL) begin
      decode_o.imm      = '0;
      decode_o.rs1_used = 1'b0;
      decode_o.rs2_used = 1'b0;
    end
  end

endmodule

// File: source/issue_queue.sv
// Circular fetch buffer with write, speculative read and commit pointers
`timescale 1ns/1ns
`include "sched_defs.svh"

module issue_queue (
  input  logic                   clk_i,
  input  logic                   arst_n_i,

  input  logic                   fe_v_i,
  input  logic [`SCHED_XLEN-1:0] fe_pc_i,
  input  logic [`SCHED_XLEN-1:0] fe_instr_i,
  input  sched_pkg::fe_fault_e   fe_fault_i,
  output logic                   fe_ready_o,

  input  logic                   deq_i,
  input  logic                   roll_i,
  input  logic                   clear_i,
  input  logic                   suppress_i,

  issue_if.queue                 issue
);

  import sched_pkg::*;

  logic [`SCHED_XLEN-1:0] pc_mem    [`SCHED_QUEUE_DEPTH];
  logic [`SCHED_XLEN-1:0] instr_mem [`SCHED_QUEUE_DEPTH];
  fe_fault_e              fault_mem [`SCHED_QUEUE_DEPTH];

  // Top bit of each pointer is the wrap bit
  logic [`SCHED_PTR_W:0] wr_ptr;
  logic [`SCHED_PTR_W:0] rd_ptr;
  logic [`SCHED_PTR_W:0] cm_ptr;

  logic full;
  logic wr_en;

  // Full counts from commit so that rolled-back entries stay stored
  assign full = (wr_ptr[`SCHED_PTR_W] != cm_ptr[`SCHED_PTR_W]) &&
                (wr_ptr[`SCHED_PTR_W-1:0] == cm_ptr[`SCHED_PTR_W-1:0]);

  assign fe_ready_o = ~full & ~suppress_i;
  assign wr_en      = fe_v_i & fe_ready_o;

  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      pc_mem[wr_ptr[`SCHED_PTR_W-1:0]]    <= fe_pc_i;
      instr_mem[wr_ptr[`SCHED_PTR_W-1:0]] <= fe_instr_i;
      fault_mem[wr_ptr[`SCHED_PTR_W-1:0]] <= fe_fault_i;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      cm_ptr <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (clear_i) begin
        rd_ptr <= wr_ptr;
        cm_ptr <= wr_ptr;
      end else if (roll_i) begin
        // Replay everything read since the last commit
        rd_ptr <= cm_ptr;
      end else begin
        if (issue.read_v) begin
          rd_ptr <= rd_ptr + 1'b1;
        end
        if (deq_i) begin
          cm_ptr <= cm_ptr + 1'b1;
        end
      end
    end
  end

  assign issue.v     = (rd_ptr != wr_ptr);
  assign issue.pc    = pc_mem[rd_ptr[`SCHED_PTR_W-1:0]];
  assign issue.instr = instr_mem[rd_ptr[`SCHED_PTR_W-1:0]];
  assign issue.fault = fault_mem[rd_ptr[`SCHED_PTR_W-1:0]];

endmodule

// File: source/issue_if.sv
// Issue queue head interface with queue, decode and dispatch modports
`timescale 1ns/1ns
`include "sched_defs.svh"

interface issue_if;

  logic                   v;
  logic [`SCHED_XLEN-1:0] pc;
  logic [`SCHED_XLEN-1:0] instr;
  sched_pkg::fe_fault_e   fault;
  // Pops the head at the next edge
  logic                   read_v;

  modport queue (output v, output pc, output instr, output fault, input read_v);

  modport decode (input instr);

  modport dispatch (input v, input pc, input instr, input fault, output read_v);

endinterface

// File: source/sched_pkg.sv
// Scheduler types: dispatch op, exception, fetch fault and decode result
`include "sched_defs.svh"

package sched_pkg;

  typedef enum logic [3:0] {
    OP_NONE,
    OP_ADD,
    OP_SUB,
    OP_AND,
    OP_OR,
    OP_XOR,
    OP_ADDI,
    OP_LW,
    OP_SW,
    OP_BEQ,
    OP_JAL,
    OP_MRET,
    OP_WFI
  } sched_op_e;

  typedef enum logic [3:0] {
    EXC_NONE,
    EXC_ILLEGAL,
    EXC_ECALL,
    EXC_EBREAK,
    EXC_FETCH_ACCESS,
    EXC_FETCH_PAGE,
    EXC_FILL,
    EXC_UNFREEZE,
    EXC_INTERRUPT
  } sched_exc_e;

  typedef enum logic [1:0] {
    FE_NONE,
    FE_ACCESS,
    FE_PAGE
  } fe_fault_e;

  typedef struct packed {
    sched_op_e                    op;
    logic [`SCHED_XLEN-1:0]       imm;
    logic [`SCHED_REG_ADDR_W-1:0] rs1_addr;
    logic [`SCHED_REG_ADDR_W-1:0] rs2_addr;
    logic                         rs1_used;
    logic                         rs2_used;
    // Only illegal, ecall, ebreak or none
    sched_exc_e                   exc;
  } decode_s;

endpackage

// File: source/sched_defs.svh
// Width and depth macros for the back-end scheduler
`ifndef SCHED_DEFS_SVH
`define SCHED_DEFS_SVH

// Data and pc width
`define SCHED_XLEN 32

// Issue queue entries as a power of two
`define SCHED_QUEUE_DEPTH 8

// Must equal log2 of the queue depth
`define SCHED_PTR_W 3

`define SCHED_REG_ADDR_W 5

`endif
